// ==== design/em_macros.svh ====
// ****************************************************************************
// efficiency monitor constants: bus and register widths, register word
// addresses and the identification words
// ****************************************************************************
`ifndef EM_MACROS_SVH
`define EM_MACROS_SVH

`define EM_AV_ADDR_WIDTH   10
`define EM_AV_DATA_WIDTH   64
`define EM_AV_BE_WIDTH     8
`define EM_BURST_WIDTH     3
`define EM_COUNT_WIDTH     32
`define EM_CSR_ADDR_WIDTH  12
`define EM_CSR_DATA_WIDTH  32

`define EM_ID_WORD         32'hdeadbeef
`define EM_VERSION         100
`define EM_REVISION        5

// only the low address bits take part in register decode
`define EM_REG_DECODE_BITS 7

`define EM_REG_ID          7'h01
`define EM_REG_VERSION     7'h02
`define EM_REG_CTRL        7'h08
`define EM_REG_WIDTHS0     7'h10
`define EM_REG_WIDTHS1     7'h11
`define EM_REG_CYCLES      7'h14
`define EM_REG_TRANSFERS   7'h18
`define EM_REG_WRITES      7'h1c
`define EM_REG_READS       7'h20
`define EM_REG_READ_BEATS  7'h24
`define EM_REG_WAITS       7'h28
`define EM_REG_IDLES       7'h34

`endif

// ==== design/em_pkg.sv ====
// ****************************************************************************
// efficiency monitor types shared by the design and the testbench
// ****************************************************************************
`include "em_macros.svh"

package em_pkg;

  // memory bus fields
  typedef logic [`EM_AV_ADDR_WIDTH-1:0] av_addr_t;
  typedef logic [`EM_AV_DATA_WIDTH-1:0] av_data_t;
  typedef logic [`EM_AV_BE_WIDTH-1:0]   av_be_t;
  typedef logic [`EM_BURST_WIDTH-1:0]   burst_t;

  // event counter value
  typedef logic [`EM_COUNT_WIDTH-1:0] count_t;

  // control register port fields
  typedef logic [`EM_CSR_ADDR_WIDTH-1:0]     csr_addr_t;
  typedef logic [`EM_CSR_DATA_WIDTH-1:0]     csr_data_t;
  typedef logic [`EM_CSR_DATA_WIDTH/8-1:0]   csr_be_t;

  // stopped while the run enable is off, armed until the first command
  typedef enum logic [1:0] {
    mon_stopped,
    mon_armed,
    mon_counting
  } mon_state_e;

endpackage

// ==== design/em_bus_sampler.sv ====
// ****************************************************************************
// efficiency monitor stage one: registered copy of the measured bus signals
// ****************************************************************************
`timescale 1ns/10ps

module em_bus_sampler (
  input  logic            avm_clk,
  input  logic            resync_ctl_reset_n,
  input  logic            avm_write,
  input  logic            avm_read,
  input  em_pkg::burst_t  avm_burstcount,
  input  logic            avs_waitrequest,
  input  logic            avs_readvalid,
  output logic            s_write,
  output logic            s_read,
  output logic            s_waitrequest,
  output logic            s_readvalid,
  output em_pkg::burst_t  s_burstcount
);

  // the bus path itself stays combinational, only this copy is timed here
  always_ff @(posedge avm_clk or negedge resync_ctl_reset_n) begin
    if (!resync_ctl_reset_n) begin
      s_write       <= 1'b0;
      s_read        <= 1'b0;
      s_waitrequest <= 1'b0;
      s_readvalid   <= 1'b0;
      s_burstcount  <= '0;
    end else begin
      s_write       <= avm_write;
      s_read        <= avm_read;
      s_waitrequest <= avs_waitrequest;
      s_readvalid   <= avs_readvalid;
      s_burstcount  <= avm_burstcount;
    end
  end

endmodule

// ==== design/em_event_classifier.sv ====
// ****************************************************************************
// efficiency monitor stage two: one-cycle event flags from each sampled cycle
// ****************************************************************************
`timescale 1ns/10ps

module em_event_classifier (
  input  logic            avm_clk,
  input  logic            resync_ctl_reset_n,
  input  logic            s_write,
  input  logic            s_read,
  input  logic            s_waitrequest,
  input  logic            s_readvalid,
  input  em_pkg::burst_t  s_burstcount,
  output logic            ev_transfer,
  output logic            ev_write,
  output logic            ev_read,
  output logic            ev_wait,
  output logic            ev_idle,
  output logic            ev_command,
  output em_pkg::burst_t  ev_read_burst
);

  logic write_accepted;
  logic read_accepted;
  logic command;

  assign command        = s_read | s_write;
  assign write_accepted = s_write & ~s_waitrequest;
  assign read_accepted  = s_read & ~s_waitrequest;

  always_ff @(posedge avm_clk or negedge resync_ctl_reset_n) begin
    if (!resync_ctl_reset_n) begin
      ev_transfer   <= 1'b0;
      ev_write      <= 1'b0;
      ev_read       <= 1'b0;
      ev_wait       <= 1'b0;
      ev_idle       <= 1'b0;
      ev_command    <= 1'b0;
      ev_read_burst <= '0;
    end else begin
      // a read beat counts as a transfer when its data comes back
      ev_transfer   <= write_accepted | s_readvalid;
      ev_write      <= write_accepted;
      ev_read       <= read_accepted;
      ev_wait       <= command & s_waitrequest;
      ev_idle       <= ~command & ~s_readvalid;
      ev_command    <= command;
      ev_read_burst <= read_accepted ? s_burstcount : '0;
    end
  end

endmodule

// ==== design/em_event_counters.sv ====
// ****************************************************************************
// efficiency monitor stage three: run state machine and wrapping counters
// ****************************************************************************
`timescale 1ns/10ps
`include "em_macros.svh"

module em_event_counters (
  input  logic                avm_clk,
  input  logic                resync_ctl_reset_n,
  input  logic                clear_req,
  input  logic                run_enable,
  input  logic                ev_transfer,
  input  logic                ev_write,
  input  logic                ev_read,
  input  logic                ev_wait,
  input  logic                ev_idle,
  input  logic                ev_command,
  input  em_pkg::burst_t      ev_read_burst,
  output em_pkg::mon_state_e  mon_state,
  output em_pkg::count_t      cycles,
  output em_pkg::count_t      transfers,
  output em_pkg::count_t      writes,
  output em_pkg::count_t      reads,
  output em_pkg::count_t      read_beats,
  output em_pkg::count_t      waits,
  output em_pkg::count_t      idles
);

  logic count_en;

  // the command that starts the measurement is counted as well
  assign count_en = run_enable &
                    ((mon_state == em_pkg::mon_counting) ||
                     (mon_state == em_pkg::mon_armed && ev_command));

  always_ff @(posedge avm_clk or negedge resync_ctl_reset_n) begin
    if (!resync_ctl_reset_n) begin
      mon_state <= em_pkg::mon_armed;
    end else if (!run_enable) begin
      mon_state <= em_pkg::mon_stopped;
    end else if (clear_req) begin
      mon_state <= em_pkg::mon_armed;
    end else begin
      case (mon_state)
        em_pkg::mon_stopped: mon_state <= em_pkg::mon_armed;
        em_pkg::mon_armed: begin
          if (ev_command) begin
            mon_state <= em_pkg::mon_counting;
          end
        end
        default: mon_state <= em_pkg::mon_counting;
      endcase
    end
  end

  // counters wrap at full scale
  always_ff @(posedge avm_clk or negedge resync_ctl_reset_n) begin
    if (!resync_ctl_reset_n) begin
      cycles     <= '0;
      transfers  <= '0;
      writes     <= '0;
      reads      <= '0;
      read_beats <= '0;
      waits      <= '0;
      idles      <= '0;
    end else if (clear_req) begin
      cycles     <= '0;
      transfers  <= '0;
      writes     <= '0;
      reads      <= '0;
      read_beats <= '0;
      waits      <= '0;
      idles      <= '0;
    end else if (count_en) begin
      cycles <= cycles + 1'b1;
      if (ev_transfer) begin
        transfers <= transfers + 1'b1;
      end
      if (ev_write) begin
        writes <= writes + 1'b1;
      end
      if (ev_read) begin
        reads      <= reads + 1'b1;
        read_beats <= read_beats +
                      {{(`EM_COUNT_WIDTH-`EM_BURST_WIDTH){1'b0}}, ev_read_burst};
      end
      if (ev_wait) begin
        waits <= waits + 1'b1;
      end
      if (ev_idle) begin
        idles <= idles + 1'b1;
      end
    end
  end

endmodule

// ==== design/em_csr_block.sv ====
// ****************************************************************************
// efficiency monitor register port with request capture, read decode, run and
// clear control, and counter snapshots taken on identification reads
// ****************************************************************************
`timescale 1ns/10ps
`include "em_macros.svh"

module em_csr_block (
  input  logic                avm_clk,
  input  logic                resync_ctl_reset_n,
  input  em_pkg::csr_addr_t   csr_addr,
  input  em_pkg::csr_be_t     csr_be,
  input  logic                csr_write_req,
  input  logic                csr_read_req,
  input  em_pkg::csr_data_t   csr_wdata,
  input  em_pkg::mon_state_e  mon_state,
  input  em_pkg::count_t      cycles,
  input  em_pkg::count_t      transfers,
  input  em_pkg::count_t      writes,
  input  em_pkg::count_t      reads,
  input  em_pkg::count_t      read_beats,
  input  em_pkg::count_t      waits,
  input  em_pkg::count_t      idles,
  output em_pkg::csr_data_t   csr_rdata,
  output logic                csr_rdata_valid,
  output logic                csr_waitrequest,
  output logic                clear_req,
  output logic                run_enable
);

  logic                          int_write_req;
  logic                          int_read_req;
  logic [`EM_REG_DECODE_BITS-1:0] int_addr;
  em_pkg::csr_be_t               int_be;
  em_pkg::csr_data_t             int_wdata;
  logic                          snapshot_req;
  em_pkg::csr_data_t             status_word;
  em_pkg::count_t                snap_cycles;
  em_pkg::count_t                snap_transfers;
  em_pkg::count_t                snap_writes;
  em_pkg::count_t                snap_reads;
  em_pkg::count_t                snap_read_beats;
  em_pkg::count_t                snap_waits;
  em_pkg::count_t                snap_idles;

  assign status_word = {6'b0, mon_state == em_pkg::mon_armed,
                        mon_state == em_pkg::mon_stopped,
                        7'b0, run_enable, 16'b0};

  always_ff @(posedge avm_clk or negedge resync_ctl_reset_n) begin
    if (!resync_ctl_reset_n) begin
      int_write_req <= 1'b0;
      int_read_req  <= 1'b0;
      int_addr      <= '0;
      int_be        <= '0;
      int_wdata     <= '0;
    end else begin
      int_write_req <= csr_write_req;
      int_read_req  <= csr_read_req;
      int_addr      <= csr_addr[`EM_REG_DECODE_BITS-1:0];
      int_be        <= csr_be;
      int_wdata     <= csr_wdata;
    end
  end

  always_ff @(posedge avm_clk or negedge resync_ctl_reset_n) begin
    if (!resync_ctl_reset_n) begin
      csr_waitrequest <= 1'b1;
      csr_rdata_valid <= 1'b0;
      csr_rdata       <= '0;
      snapshot_req    <= 1'b0;
      clear_req       <= 1'b0;
      run_enable      <= 1'b1;
    end else begin
      csr_waitrequest <= 1'b0;
      csr_rdata_valid <= int_read_req;
      snapshot_req    <= int_read_req && int_addr == `EM_REG_ID;
      // writing a zero to bit 0 requests a clear
      clear_req <= int_write_req && int_addr == `EM_REG_CTRL && int_be[0] && !int_wdata[0];
      if (int_write_req && int_addr == `EM_REG_CTRL && int_be[2]) begin
        run_enable <= int_wdata[16];
      end
      if (int_read_req) begin
        case (int_addr)
          `EM_REG_ID:         csr_rdata <= `EM_ID_WORD;
          `EM_REG_VERSION:    csr_rdata <= {16'(`EM_VERSION), 16'(`EM_REVISION)};
          `EM_REG_CTRL:       csr_rdata <= status_word;
          `EM_REG_WIDTHS0:    csr_rdata <= {16'(`EM_AV_ADDR_WIDTH), 16'(`EM_AV_DATA_WIDTH)};
          `EM_REG_WIDTHS1:    csr_rdata <= {16'(`EM_AV_BE_WIDTH), 16'(`EM_BURST_WIDTH)};
          `EM_REG_CYCLES:     csr_rdata <= snap_cycles;
          `EM_REG_TRANSFERS:  csr_rdata <= snap_transfers;
          `EM_REG_WRITES:     csr_rdata <= snap_writes;
          `EM_REG_READS:      csr_rdata <= snap_reads;
          `EM_REG_READ_BEATS: csr_rdata <= snap_read_beats;
          `EM_REG_WAITS:      csr_rdata <= snap_waits;
          `EM_REG_IDLES:      csr_rdata <= snap_idles;
          default:            csr_rdata <= '0;
        endcase
      end
    end
  end

  // counters are read back from the copy taken at the last identification read
  always_ff @(posedge avm_clk or negedge resync_ctl_reset_n) begin
    if (!resync_ctl_reset_n) begin
      snap_cycles     <= '0;
      snap_transfers  <= '0;
      snap_writes     <= '0;
      snap_reads      <= '0;
      snap_read_beats <= '0;
      snap_waits      <= '0;
      snap_idles      <= '0;
    end else if (snapshot_req) begin
      snap_cycles     <= cycles;
      snap_transfers  <= transfers;
      snap_writes     <= writes;
      snap_reads      <= reads;
      snap_read_beats <= read_beats;
      snap_waits      <= waits;
      snap_idles      <= idles;
    end
  end

endmodule

// ==== design/em_single_top.sv ====
// ****************************************************************************
// memory bus efficiency monitor, passes the bus through unchanged and
// measures it in a sample, classify and count pipeline
// ****************************************************************************
`timescale 1ns/10ps

module em_single_top (
  input  logic               avm_clk,
  input  logic               resync_ctl_reset_n,
  input  em_pkg::csr_addr_t  csr_addr,
  input  em_pkg::csr_be_t    csr_be,
  input  logic               csr_write_req,
  input  logic               csr_read_req,
  input  em_pkg::csr_data_t  csr_wdata,
  output em_pkg::csr_data_t  csr_rdata,
  output logic               csr_rdata_valid,
  output logic               csr_waitrequest,
  input  em_pkg::av_addr_t   avm_address,
  input  em_pkg::av_be_t     avm_be,
  input  em_pkg::burst_t     avm_burstcount,
  input  logic               avm_beginbursttransfer,
  output logic               avm_waitrequest,
  input  logic               avm_write,
  input  logic               avm_read,
  output logic               avm_readvalid,
  input  em_pkg::av_data_t   avm_wdata,
  output em_pkg::av_data_t   avm_rdata,
  output em_pkg::av_addr_t   avs_address,
  output em_pkg::av_be_t     avs_be,
  output em_pkg::burst_t     avs_burstcount,
  output logic               avs_beginbursttransfer,
  input  logic               avs_waitrequest,
  output logic               avs_write,
  output logic               avs_read,
  input  logic               avs_readvalid,
  output em_pkg::av_data_t   avs_wdata,
  input  em_pkg::av_data_t   avs_rdata
);

  logic                s_write;
  logic                s_read;
  logic                s_waitrequest;
  logic                s_readvalid;
  em_pkg::burst_t      s_burstcount;
  logic                ev_transfer;
  logic                ev_write;
  logic                ev_read;
  logic                ev_wait;
  logic                ev_idle;
  logic                ev_command;
  em_pkg::burst_t      ev_read_burst;
  logic                clear_req;
  logic                run_enable;
  em_pkg::mon_state_e  mon_state;
  em_pkg::count_t      cycles;
  em_pkg::count_t      transfers;
  em_pkg::count_t      writes;
  em_pkg::count_t      reads;
  em_pkg::count_t      read_beats;
  em_pkg::count_t      waits;
  em_pkg::count_t      idles;

  // the monitor only observes, back-pressure stays with the slave
  assign avs_address            = avm_address;
  assign avs_be                 = avm_be;
  assign avs_burstcount         = avm_burstcount;
  assign avs_beginbursttransfer = avm_beginbursttransfer;
  assign avs_write              = avm_write;
  assign avs_read               = avm_read;
  assign avs_wdata              = avm_wdata;
  assign avm_waitrequest        = avs_waitrequest;
  assign avm_readvalid          = avs_readvalid;
  assign avm_rdata              = avs_rdata;

  em_bus_sampler em_bus_sampler_i (
    .avm_clk            (avm_clk),
    .resync_ctl_reset_n (resync_ctl_reset_n),
    .avm_write          (avm_write),
    .avm_read           (avm_read),
    .avm_burstcount     (avm_burstcount),
    .avs_waitrequest    (avs_waitrequest),
    .avs_readvalid      (avs_readvalid),
    .s_write            (s_write),
    .s_read             (s_read),
    .s_waitrequest      (s_waitrequest),
    .s_readvalid        (s_readvalid),
    .s_burstcount       (s_burstcount)
  );

  em_event_classifier em_event_classifier_i (
    .avm_clk            (avm_clk),
    .resync_ctl_reset_n (resync_ctl_reset_n),
    .s_write            (s_write),
    .s_read             (s_read),
    .s_waitrequest      (s_waitrequest),
    .s_readvalid        (s_readvalid),
    .s_burstcount       (s_burstcount),
    .ev_transfer        (ev_transfer),
    .ev_write           (ev_write),
    .ev_read            (ev_read),
    .ev_wait            (ev_wait),
    .ev_idle            (ev_idle),
    .ev_command         (ev_command),
    .ev_read_burst      (ev_read_burst)
  );

  em_event_counters em_event_counters_i (
    .avm_clk            (avm_clk),
    .resync_ctl_reset_n (resync_ctl_reset_n),
    .clear_req          (clear_req),
    .run_enable         (run_enable),
    .ev_transfer        (ev_transfer),
    .ev_write           (ev_write),
    .ev_read            (ev_read),
    .ev_wait            (ev_wait),
    .ev_idle            (ev_idle),
    .ev_command         (ev_command),
    .ev_read_burst      (ev_read_burst),
    .mon_state          (mon_state),
    .cycles             (cycles),
    .transfers          (transfers),
    .writes             (writes),
    .reads              (reads),
    .read_beats         (read_beats),
    .waits              (waits),
    .idles              (idles)
  );

  em_csr_block em_csr_block_i (
    .avm_clk            (avm_clk),
    .resync_ctl_reset_n (resync_ctl_reset_n),
    .csr_addr           (csr_addr),
    .csr_be             (csr_be),
    .csr_write_req      (csr_write_req),
    .csr_read_req       (csr_read_req),
    .csr_wdata          (csr_wdata),
    .mon_state          (mon_state),
    .cycles             (cycles),
    .transfers          (transfers),
    .writes             (writes),
    .reads              (reads),
    .read_beats         (read_beats),
    .waits              (waits),
    .idles              (idles),
    .csr_rdata          (csr_rdata),
    .csr_rdata_valid    (csr_rdata_valid),
    .csr_waitrequest    (csr_waitrequest),
    .clear_req          (clear_req),
    .run_enable         (run_enable)
  );

endmodule

// ==== bench/em_single_chk.sv ====
// ****************************************************************************
// efficiency monitor protocol assertions, bound to the top level
// ****************************************************************************
`timescale 1ns/10ps

module em_single_chk (
  input logic avm_clk,
  input logic resync_ctl_reset_n,
  input logic csr_read_req,
  input logic csr_rdata_valid,
  input logic avm_waitrequest,
  input logic avs_waitrequest,
  input logic avm_write,
  input logic avs_write
);

  // read data answers a request taken two edges before
  rdata_valid_after_req: assert property (@(posedge avm_clk) disable iff (!resync_ctl_reset_n)
    csr_rdata_valid |-> $past(csr_read_req, 2))
    else $error("csr_rdata_valid without a read request two cycles earlier");

  waitrequest_passed: assert property (@(posedge avm_clk) disable iff (!resync_ctl_reset_n)
    avm_waitrequest == avs_waitrequest)
    else $error("avm_waitrequest differs from avs_waitrequest");

  write_passed: assert property (@(posedge avm_clk) disable iff (!resync_ctl_reset_n)
    avs_write == avm_write)
    else $error("avs_write differs from avm_write");

endmodule

bind em_single_top em_single_chk em_single_chk_i (
  .avm_clk            (avm_clk),
  .resync_ctl_reset_n (resync_ctl_reset_n),
  .csr_read_req       (csr_read_req),
  .csr_rdata_valid    (csr_rdata_valid),
  .avm_waitrequest    (avm_waitrequest),
  .avs_waitrequest    (avs_waitrequest),
  .avm_write          (avm_write),
  .avs_write          (avs_write)
);

// ==== bench/em_single_tb.sv ====
// ****************************************************************************
// directed testbench for the memory bus efficiency monitor, with a simple
// slave model, register port tasks and the monitor tests
// ****************************************************************************
`timescale 1ns/10ps
`include "em_macros.svh"

module em_single_tb;

  logic               avm_clk;
  logic               resync_ctl_reset_n;
  em_pkg::csr_addr_t  csr_addr;
  em_pkg::csr_be_t    csr_be;
  logic               csr_write_req;
  logic               csr_read_req;
  em_pkg::csr_data_t  csr_wdata;
  em_pkg::csr_data_t  csr_rdata;
  logic               csr_rdata_valid;
  logic               csr_waitrequest;
  em_pkg::av_addr_t   avm_address;
  em_pkg::av_be_t     avm_be;
  em_pkg::burst_t     avm_burstcount;
  logic               avm_beginbursttransfer;
  logic               avm_waitrequest;
  logic               avm_write;
  logic               avm_read;
  logic               avm_readvalid;
  em_pkg::av_data_t   avm_wdata;
  em_pkg::av_data_t   avm_rdata;
  em_pkg::av_addr_t   avs_address;
  em_pkg::av_be_t     avs_be;
  em_pkg::burst_t     avs_burstcount;
  logic               avs_beginbursttransfer;
  logic               avs_waitrequest;
  logic               avs_write;
  logic               avs_read;
  logic               avs_readvalid;
  em_pkg::av_data_t   avs_wdata;
  em_pkg::av_data_t   avs_rdata;
  integer             seed;

  em_single_top em_single_top_i (.*);

  initial begin
    avm_clk = 1'b0;
    forever #50 avm_clk = ~avm_clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_equal(input string name, input em_pkg::csr_data_t expected,
                             input em_pkg::csr_data_t actual);
    assert (actual == expected) else begin
      report_failure($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_at_least(input string name, input em_pkg::csr_data_t expected,
                                input em_pkg::csr_data_t actual);
    assert (actual >= expected) else begin
      report_failure($sformatf("mismatch %s expected at least %0d actual %0d",
                               name, expected, actual));
    end
  endtask

  // every task starts and ends 10 ns after a rising edge
  task automatic next_cycle();
    @(posedge avm_clk);
    #10;
  endtask

  task automatic init_inputs();
    csr_addr               = '0;
    csr_be                 = '0;
    csr_write_req          = 1'b0;
    csr_read_req           = 1'b0;
    csr_wdata              = '0;
    avm_address            = '0;
    avm_be                 = '0;
    avm_burstcount         = '0;
    avm_beginbursttransfer = 1'b0;
    avm_write              = 1'b0;
    avm_read               = 1'b0;
    avm_wdata              = '0;
    avs_waitrequest        = 1'b0;
    avs_readvalid          = 1'b0;
    avs_rdata              = '0;
  endtask

  task automatic csr_read(input logic [`EM_REG_DECODE_BITS-1:0] reg_addr,
                          output em_pkg::csr_data_t data);
    int waited;
    waited       = 0;
    data         = '0;
    csr_addr     = {{(`EM_CSR_ADDR_WIDTH-`EM_REG_DECODE_BITS){1'b0}}, reg_addr};
    csr_read_req = 1'b1;
    next_cycle();
    csr_read_req = 1'b0;
    while (!csr_rdata_valid && waited < 10) begin
      next_cycle();
      waited++;
    end
    if (!csr_rdata_valid) begin
      report_failure("timeout waiting for csr_rdata_valid");
    end else begin
      data = csr_rdata;
      next_cycle();
      assert (!csr_rdata_valid) else begin
        report_failure("csr_rdata_valid stayed high for more than one cycle");
      end
    end
  endtask

  task automatic csr_write(input logic [`EM_REG_DECODE_BITS-1:0] reg_addr,
                           input em_pkg::csr_be_t be, input em_pkg::csr_data_t data);
    csr_addr      = {{(`EM_CSR_ADDR_WIDTH-`EM_REG_DECODE_BITS){1'b0}}, reg_addr};
    csr_be        = be;
    csr_wdata     = data;
    csr_write_req = 1'b1;
    next_cycle();
    csr_write_req = 1'b0;
    // give the clear pulse and the run state machine time to settle
    repeat (3) next_cycle();
  endtask

  task automatic drive_idle(input int cycles);
    avm_write       = 1'b0;
    avm_read        = 1'b0;
    avs_waitrequest = 1'b0;
    avs_readvalid   = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
    end
  endtask

  task automatic bus_write(input int n_wait);
    logic [31:0] rnd;
    rnd             = $random(seed);
    avm_address     = rnd[`EM_AV_ADDR_WIDTH-1:0];
    avm_be          = '1;
    avm_burstcount  = 3'd1;
    avm_wdata       = {$random(seed), $random(seed)};
    avm_write       = 1'b1;
    avs_waitrequest = 1'b1;
    for (int i = 0; i < n_wait; i++) begin
      next_cycle();
    end
    avs_waitrequest = 1'b0;
    next_cycle();
    avm_write = 1'b0;
  endtask

  task automatic bus_read(input int beats, input int n_wait);
    logic [31:0] rnd;
    rnd             = $random(seed);
    avm_address     = rnd[`EM_AV_ADDR_WIDTH-1:0];
    avm_burstcount  = em_pkg::burst_t'(beats);
    avm_read        = 1'b1;
    avs_waitrequest = 1'b1;
    for (int i = 0; i < n_wait; i++) begin
      next_cycle();
    end
    avs_waitrequest = 1'b0;
    next_cycle();
    avm_read      = 1'b0;
    avs_readvalid = 1'b1;
    for (int i = 0; i < beats; i++) begin
      avs_rdata = {$random(seed), $random(seed)};
      next_cycle();
    end
    avs_readvalid = 1'b0;
  endtask

  task automatic test_identification();
    em_pkg::csr_data_t value;
    csr_read(`EM_REG_ID, value);
    check_equal("identification id", `EM_ID_WORD, value);
    csr_read(`EM_REG_VERSION, value);
    check_equal("identification version", (`EM_VERSION << 16) | `EM_REVISION, value);
    csr_read(`EM_REG_WIDTHS0, value);
    check_equal("identification widths0", (`EM_AV_ADDR_WIDTH << 16) | `EM_AV_DATA_WIDTH,
                value);
    csr_read(`EM_REG_WIDTHS1, value);
    check_equal("identification widths1", (`EM_AV_BE_WIDTH << 16) | `EM_BURST_WIDTH, value);
    csr_read(7'h3c, value);
    check_equal("identification undecoded", 32'h0, value);
  endtask

  task automatic test_pass_through();
    logic [31:0] rnd;
    logic [87:0] fwd_exp;
    logic [87:0] fwd_act;
    logic [65:0] back_exp;
    logic [65:0] back_act;
    for (int i = 0; i < 20; i++) begin
      rnd                    = $random(seed);
      avm_address            = rnd[9:0];
      avm_be                 = rnd[17:10];
      avm_burstcount         = rnd[20:18];
      avm_beginbursttransfer = rnd[21];
      avm_write              = rnd[22];
      avm_read               = rnd[23];
      avs_waitrequest        = rnd[24];
      avs_readvalid          = rnd[25];
      avm_wdata              = {$random(seed), $random(seed)};
      avs_rdata              = {$random(seed), $random(seed)};
      #5;
      fwd_exp  = {avm_address, avm_be, avm_burstcount, avm_beginbursttransfer,
                  avm_write, avm_read, avm_wdata};
      fwd_act  = {avs_address, avs_be, avs_burstcount, avs_beginbursttransfer,
                  avs_write, avs_read, avs_wdata};
      back_exp = {avs_waitrequest, avs_readvalid, avs_rdata};
      back_act = {avm_waitrequest, avm_readvalid, avm_rdata};
      assert (fwd_act == fwd_exp) else begin
        report_failure($sformatf("mismatch pass_through master to slave expected %h actual %h",
                                 fwd_exp, fwd_act));
      end
      assert (back_act == back_exp) else begin
        report_failure($sformatf("mismatch pass_through slave to master expected %h actual %h",
                                 back_exp, back_act));
      end
      next_cycle();
    end
    avm_beginbursttransfer = 1'b0;
    drive_idle(4);
  endtask

  task automatic test_counting();
    em_pkg::csr_data_t value;
    int exp_writes;
    int exp_reads;
    int exp_waits;
    int exp_beats;
    int n_wait;
    int beats;
    exp_writes = 0;
    exp_reads  = 0;
    exp_waits  = 0;
    exp_beats  = 0;
    // clear and keep the run bit set
    csr_write(`EM_REG_CTRL, 4'b0101, 32'h0001_0000);
    for (int i = 0; i < 5; i++) begin
      n_wait = $unsigned($random(seed)) % 3;
      bus_write(n_wait);
      exp_writes++;
      exp_waits += n_wait;
      n_wait = $unsigned($random(seed)) % 3;
      beats  = $unsigned($random(seed)) % 7 + 1;
      bus_read(beats, n_wait);
      exp_reads++;
      exp_waits += n_wait;
      exp_beats += beats;
    end
    drive_idle(4);
    csr_read(`EM_REG_ID, value);
    csr_read(`EM_REG_WRITES, value);
    check_equal("counting writes", exp_writes, value);
    csr_read(`EM_REG_READS, value);
    check_equal("counting reads", exp_reads, value);
    csr_read(`EM_REG_WAITS, value);
    check_equal("counting waits", exp_waits, value);
    csr_read(`EM_REG_READ_BEATS, value);
    check_equal("counting read beats", exp_beats, value);
    csr_read(`EM_REG_TRANSFERS, value);
    check_equal("counting transfers", exp_writes + exp_beats, value);
    csr_read(`EM_REG_IDLES, value);
    check_at_least("counting idles", 4, value);
    csr_read(`EM_REG_CYCLES, value);
    check_at_least("counting cycles", exp_writes + exp_reads + exp_waits + exp_beats + 4,
                   value);
  endtask

  task automatic test_run_control();
    em_pkg::csr_data_t value;
    logic [`EM_REG_DECODE_BITS-1:0] counter_regs [7];
    counter_regs = '{`EM_REG_CYCLES, `EM_REG_TRANSFERS, `EM_REG_WRITES, `EM_REG_READS,
                     `EM_REG_READ_BEATS, `EM_REG_WAITS, `EM_REG_IDLES};
    csr_write(`EM_REG_CTRL, 4'b0100, 32'h0);
    csr_read(`EM_REG_CTRL, value);
    check_equal("run control stopped", 32'h0100_0000, value & 32'h0301_0000);
    csr_write(`EM_REG_CTRL, 4'b0001, 32'h0);
    bus_write(1);
    bus_read(4, 0);
    drive_idle(4);
    csr_read(`EM_REG_ID, value);
    for (int i = 0; i < 7; i++) begin
      csr_read(counter_regs[i], value);
      check_equal("run control stopped counter", 32'h0, value);
    end
    csr_write(`EM_REG_CTRL, 4'b0100, 32'h0001_0000);
    csr_read(`EM_REG_CTRL, value);
    check_equal("run control armed", 32'h0201_0000, value & 32'h0301_0000);
    bus_write(0);
    drive_idle(4);
    csr_read(`EM_REG_CTRL, value);
    check_equal("run control counting", 32'h0001_0000, value & 32'h0301_0000);
  endtask

  task automatic test_snapshot_hold();
    em_pkg::csr_data_t value;
    em_pkg::csr_data_t base_writes;
    em_pkg::csr_data_t base_beats;
    csr_read(`EM_REG_ID, value);
    csr_read(`EM_REG_WRITES, base_writes);
    csr_read(`EM_REG_READ_BEATS, base_beats);
    bus_write(0);
    bus_write(1);
    bus_read(3, 1);
    drive_idle(4);
    csr_read(`EM_REG_WRITES, value);
    check_equal("snapshot hold writes", base_writes, value);
    csr_read(`EM_REG_READ_BEATS, value);
    check_equal("snapshot hold read beats", base_beats, value);
    csr_read(`EM_REG_ID, value);
    csr_read(`EM_REG_WRITES, value);
    check_equal("snapshot update writes", base_writes + 2, value);
    csr_read(`EM_REG_READ_BEATS, value);
    check_equal("snapshot update read beats", base_beats + 3, value);
  endtask

  initial begin
    int waited;
    seed = 99;
    init_inputs();
    resync_ctl_reset_n = 1'b0;
    repeat (10) @(posedge avm_clk);
    #10;
    resync_ctl_reset_n = 1'b1;
    waited = 0;
    while (csr_waitrequest && waited < 10) begin
      next_cycle();
      waited++;
    end
    if (csr_waitrequest) begin
      report_failure("csr_waitrequest stayed high after reset");
    end else begin
      test_identification();
      test_pass_through();
      test_counting();
      test_run_control();
      test_snapshot_hold();
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+design
design/em_pkg.sv
design/em_bus_sampler.sv
design/em_event_classifier.sv
design/em_event_counters.sv
design/em_csr_block.sv
design/em_single_top.sv
bench/em_single_chk.sv
bench/em_single_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/10ps
TOP       = em_single_tb
FILE_LIST = files.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILE_LIST)) $(wildcard design/*.svh)

.PHONY: run clean

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; \
	elif grep -q "RESULT: PASS" $(LOG); then echo "simulation passed"; \
	else echo "simulation ended without a result"; exit 1; fi

$(SIM): $(SOURCES) $(FILE_LIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
